/* design/io_defs.svh */
`ifndef IO_DEFS_SVH
`define IO_DEFS_SVH

// Dekatron counter geometry
`define IO_DEKATRON_WIDTH 4
`define IO_IP_DIGITS      4
`define IO_LOOP_DIGITS    5
`define IO_AP_DIGITS      4
`define IO_DATA_DIGITS    4

// IN-12 display
`define IO_ANODES         10   // One anode per scan frame

// Keyboard matrix
`define IO_KB_COLUMNS     8
`define IO_KB_ROWS_USED   5    // Rows kept per column
`define IO_KEY_BITS       40   // Columns times kept rows

// Clock_1us cycles between scan ticks
// A frame takes 7 cycles, so this must stay at 8 or more
`define IO_SCAN_DIVIDE    16

`endif

/* design/ioPkg.sv */
package ioPkg;

    // Phase of one front-panel bus frame, also the emulData select
    typedef enum logic [2:0] {
        PhaseIdle,      // Bus parked at zero
        PhaseBlank,     // Tubes blanked
        PhaseCathodes,  // Cathode byte on the bus
        PhaseAnodes,    // Anode number on the bus
        PhaseKeyWrite,  // Keyboard column on the bus
        PhaseKeyRead,   // Rows sampled
        PhaseStop       // Counters advance
    } busPhase;

    // IN-12 cathode wiring, digit value to pin code
    function automatic logic [3:0] in12Pin(input logic [3:0] digit);
        logic [3:0] pin;
        case (digit)
            4'd0: pin = 4'd1;
            4'd1: pin = 4'd0;
            4'd2: pin = 4'd9;
            4'd3: pin = 4'd8;
            4'd4: pin = 4'd7;
            4'd5: pin = 4'd6;
            4'd6: pin = 4'd5;
            4'd7: pin = 4'd4;
            4'd8: pin = 4'd3;
            4'd9: pin = 4'd2;
            default: pin = 4'd15;  // No cathode lit
        endcase
        return pin;
    endfunction

endpackage

/* design/scanTimer.sv */
`timescale 1ns/10ps

`include "io_defs.svh"

module scanTimer #(
    parameter int scanDivide = `IO_SCAN_DIVIDE
) (
    input  logic       Clock_1us,
    input  logic       reset,
    input  logic       frameDone,
    output logic       scanTick,
    output logic [3:0] anodeIndex,
    output logic [2:0] kbRow
);

    localparam int countWidth = $clog2(scanDivide);

    logic [countWidth-1:0] divCount;  // Cycles left to the next tick

    // Down-counter with reload, tick registered one cycle after zero
    always_ff @(posedge Clock_1us) begin
        if (reset) begin
            divCount <= countWidth'(scanDivide - 1);
            scanTick <= 1'b0;
        end else begin
            scanTick <= (divCount == '0);
            if (divCount == '0) begin
                divCount <= countWidth'(scanDivide - 1);
            end else begin
                divCount <= divCount - 1'b1;
            end
        end
    end

    // Anode and keyboard row share the frame rhythm
    always_ff @(posedge Clock_1us) begin
        if (reset) begin
            anodeIndex <= 4'd0;
            kbRow      <= 3'd0;
        end else if (frameDone) begin
            if (anodeIndex == 4'(`IO_ANODES - 1)) begin
                anodeIndex <= 4'd0;  // Wrap after the last anode
            end else begin
                anodeIndex <= anodeIndex + 4'd1;
            end
            kbRow <= kbRow + 3'd1;  // Eight columns, natural wrap
        end
    end

endmodule

/* design/cathodeSelect.sv */
`timescale 1ns/10ps

`include "io_defs.svh"

module cathodeSelect (
    input  logic [3:0] anodeIndex,
    input  logic [`IO_IP_DIGITS*`IO_DEKATRON_WIDTH-1:0]   ipCounter,
    input  logic [`IO_LOOP_DIGITS*`IO_DEKATRON_WIDTH-1:0] loopCounter,
    input  logic [`IO_AP_DIGITS*`IO_DEKATRON_WIDTH-1:0]   apCounter,
    input  logic [`IO_DATA_DIGITS*`IO_DEKATRON_WIDTH-1:0] dataCounter,
    output logic [7:0] cathodeByte
);

    logic [`IO_DEKATRON_WIDTH-1:0] highDigit;
    logic [`IO_DEKATRON_WIDTH-1:0] lowDigit;

    // Upper tube of each anode: loop digits, then IP digits
    always_comb begin
        case (anodeIndex)
            4'd0: highDigit = loopCounter[3:0];
            4'd1: highDigit = loopCounter[7:4];
            4'd2: highDigit = loopCounter[11:8];
            4'd3: highDigit = loopCounter[15:12];
            4'd4: highDigit = loopCounter[19:16];
            4'd5: highDigit = ipCounter[3:0];
            4'd6: highDigit = ipCounter[7:4];
            4'd7: highDigit = ipCounter[11:8];
            4'd8: highDigit = ipCounter[15:12];
            default: highDigit = 4'd0;  // Anode 9 and unused codes
        endcase
    end

    // Lower tube: data digits, a blank slot, then AP digits
    always_comb begin
        case (anodeIndex)
            4'd0: lowDigit = dataCounter[3:0];
            4'd1: lowDigit = dataCounter[7:4];
            4'd2: lowDigit = dataCounter[11:8];
            4'd3: lowDigit = dataCounter[15:12];
            4'd4: lowDigit = 4'd0;  // Loop has one digit more than data
            4'd5: lowDigit = apCounter[3:0];
            4'd6: lowDigit = apCounter[7:4];
            4'd7: lowDigit = apCounter[11:8];
            4'd8: lowDigit = apCounter[15:12];
            default: lowDigit = 4'd0;
        endcase
    end

    // High pin code in the upper nibble
    assign cathodeByte = {ioPkg::in12Pin(highDigit), ioPkg::in12Pin(lowDigit)};

endmodule

/* design/keyboardScanner.sv */
`timescale 1ns/10ps

`include "io_defs.svh"

module keyboardScanner (
    input  logic                          Clock_1us,
    input  logic                          reset,
    input  logic [2:0]                    kbRow,
    input  logic                          keyRead,
    input  logic [6:0]                    keyboardData,
    output logic [`IO_KB_COLUMNS-1:0]     columnSelect,
    output logic [`IO_KEY_BITS-1:0]       keysCurrentState
);

    logic [`IO_KB_ROWS_USED-1:0] rowBits;

    // One-hot drive for the active keyboard column
    assign columnSelect = `IO_KB_COLUMNS'(1) << kbRow;

    // Rows 6 and 5 carry no keys
    assign rowBits = keyboardData[`IO_KB_ROWS_USED-1:0];

    // Key map, one slice per column, refreshed when that column is read
    always_ff @(posedge Clock_1us) begin
        if (reset) begin
            keysCurrentState <= '0;
        end else if (keyRead) begin
            keysCurrentState[kbRow*`IO_KB_ROWS_USED +: `IO_KB_ROWS_USED] <= rowBits;
        end
    end

endmodule

/* design/busSequencer.sv */
`timescale 1ns/10ps

module busSequencer (
    input  logic           Clock_1us,
    input  logic           reset,
    input  logic           scanTick,
    output ioPkg::busPhase phase,
    output logic           in12Clear,
    output logic           in12WriteCathode,
    output logic           in12WriteAnode,
    output logic           keyboardWrite,
    output logic           keyRead,
    output logic           frameDone
);

    ioPkg::busPhase nextPhase;

    // One phase per clock once a tick starts the frame
    always_comb begin
        nextPhase = phase;
        case (phase)
            ioPkg::PhaseIdle: begin
                if (scanTick) begin
                    nextPhase = ioPkg::PhaseBlank;
                end
            end
            ioPkg::PhaseBlank: begin
                nextPhase = ioPkg::PhaseCathodes;
            end
            ioPkg::PhaseCathodes: begin
                nextPhase = ioPkg::PhaseAnodes;
            end
            ioPkg::PhaseAnodes: begin
                nextPhase = ioPkg::PhaseKeyWrite;
            end
            ioPkg::PhaseKeyWrite: begin
                nextPhase = ioPkg::PhaseKeyRead;
            end
            ioPkg::PhaseKeyRead: begin
                nextPhase = ioPkg::PhaseStop;
            end
            ioPkg::PhaseStop: begin
                nextPhase = ioPkg::PhaseIdle;
            end
            default: begin
                nextPhase = ioPkg::PhaseIdle;  // Unused encoding
            end
        endcase
    end

    always_ff @(posedge Clock_1us) begin
        if (reset) begin
            phase <= ioPkg::PhaseIdle;
        end else begin
            phase <= nextPhase;
        end
    end

    // Strobes decoded from the next phase so they line up with the phase itself
    always_ff @(posedge Clock_1us) begin
        if (reset) begin
            in12Clear        <= 1'b0;
            in12WriteCathode <= 1'b0;
            in12WriteAnode   <= 1'b0;
            keyboardWrite    <= 1'b0;
            keyRead          <= 1'b0;
            frameDone        <= 1'b0;
        end else begin
            in12Clear        <= (nextPhase == ioPkg::PhaseBlank);
            in12WriteCathode <= (nextPhase == ioPkg::PhaseCathodes);
            in12WriteAnode   <= (nextPhase == ioPkg::PhaseAnodes);
            keyboardWrite    <= (nextPhase == ioPkg::PhaseKeyWrite);
            keyRead          <= (nextPhase == ioPkg::PhaseKeyRead);
            frameDone        <= (nextPhase == ioPkg::PhaseStop);  // Steps the counters
        end
    end

endmodule

/* design/ioKeyDisplay.sv */
`timescale 1ns/10ps

`include "io_defs.svh"

module ioKeyDisplay (
    input  logic                                          Clock_1us,
    input  logic                                          reset,
    input  logic [6:0]                                    keyboardData,
    input  logic [`IO_IP_DIGITS*`IO_DEKATRON_WIDTH-1:0]   ipCounter,
    input  logic [`IO_LOOP_DIGITS*`IO_DEKATRON_WIDTH-1:0] loopCounter,
    input  logic [`IO_AP_DIGITS*`IO_DEKATRON_WIDTH-1:0]   apCounter,
    input  logic [`IO_DATA_DIGITS*`IO_DEKATRON_WIDTH-1:0] dataCounter,
    output logic [7:0]                                    emulData,
    output logic                                          in12Clear,
    output logic                                          in12WriteCathode,
    output logic                                          in12WriteAnode,
    output logic                                          keyboardWrite,
    output logic [`IO_KEY_BITS-1:0]                       keysCurrentState
);

    logic                       scanTick;
    logic                       frameDone;
    logic                       keyRead;
    logic [3:0]                 anodeIndex;
    logic [2:0]                 kbRow;
    logic [7:0]                 cathodeByte;
    logic [`IO_KB_COLUMNS-1:0]  columnSelect;
    ioPkg::busPhase             phase;

    scanTimer #(
        .scanDivide(`IO_SCAN_DIVIDE)
    ) scanTimerInst (
        .Clock_1us  (Clock_1us),
        .reset      (reset),
        .frameDone  (frameDone),
        .scanTick   (scanTick),
        .anodeIndex (anodeIndex),
        .kbRow      (kbRow)
    );

    cathodeSelect cathodeSelectInst (
        .anodeIndex  (anodeIndex),
        .ipCounter   (ipCounter),
        .loopCounter (loopCounter),
        .apCounter   (apCounter),
        .dataCounter (dataCounter),
        .cathodeByte (cathodeByte)
    );

    keyboardScanner keyboardScannerInst (
        .Clock_1us        (Clock_1us),
        .reset            (reset),
        .kbRow            (kbRow),
        .keyRead          (keyRead),
        .keyboardData     (keyboardData),
        .columnSelect     (columnSelect),
        .keysCurrentState (keysCurrentState)
    );

    busSequencer busSequencerInst (
        .Clock_1us        (Clock_1us),
        .reset            (reset),
        .scanTick         (scanTick),
        .phase            (phase),
        .in12Clear        (in12Clear),
        .in12WriteCathode (in12WriteCathode),
        .in12WriteAnode   (in12WriteAnode),
        .keyboardWrite    (keyboardWrite),
        .keyRead          (keyRead),
        .frameDone        (frameDone)
    );

    // Shared bus, parked at zero outside the write phases
    always_comb begin
        case (phase)
            ioPkg::PhaseCathodes: emulData = cathodeByte;
            ioPkg::PhaseAnodes:   emulData = {4'b0000, anodeIndex};
            ioPkg::PhaseKeyWrite: emulData = columnSelect;
            default:              emulData = 8'h00;
        endcase
    end

endmodule

/* testbench/ioStimulus.svh */
`ifndef IO_STIMULUS_SVH
`define IO_STIMULUS_SVH

localparam int frameCount = 24;

// One scan frame: counters and rows driven, bus bytes and key map expected
typedef struct packed {
    logic [15:0]             ip;
    logic [19:0]             loop;
    logic [15:0]             ap;
    logic [15:0]             data;
    logic [6:0]              kb;       // Keyboard rows from the LFSR
    logic [7:0]              cathode;  // Expected bus byte per write phase
    logic [7:0]              anode;
    logic [7:0]              column;
    logic [`IO_KEY_BITS-1:0] keys;     // Expected key map after the frame
} frameEntry;

frameEntry frameTable [frameCount];

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// IN-12 wiring: 0 and 1 swapped, 2 to 9 reversed, anything else dark
function automatic logic [3:0] pinCode(input logic [3:0] digit);
    if (digit > 4'd9) return 4'hF;
    if (digit < 4'd2) return 4'd1 - digit;
    return 4'd11 - digit;
endfunction

// Loop and IP digits on the upper tube, data and AP digits on the lower one
function automatic logic [7:0] modelCathode(input frameEntry entry, input int anode);
    logic [3:0] high;
    logic [3:0] low;
    high = 4'd0;
    low  = 4'd0;
    if (anode < 5) high = entry.loop[4*anode +: 4];
    else if (anode < 9) high = entry.ip[4*(anode-5) +: 4];
    if (anode < 4) low = entry.data[4*anode +: 4];
    else if (anode >= 5 && anode < 9) low = entry.ap[4*(anode-5) +: 4];
    return {pinCode(high), pinCode(low)};
endfunction

task automatic setCounters(input int k, input logic [15:0] ip, input logic [19:0] loop,
                           input logic [15:0] ap, input logic [15:0] data);
    frameTable[k].ip   = ip;
    frameTable[k].loop = loop;
    frameTable[k].ap   = ap;
    frameTable[k].data = data;
endtask

// Columns: frame, IP, loop, AP, data
task automatic loadCounters();
    setCounters(0,  16'h1234, 20'h5678A, 16'h9012, 16'h345F);
    setCounters(1,  16'h0987, 20'h6B543, 16'h2109, 16'h87C6);
    setCounters(2,  16'h4455, 20'h66D77, 16'h8899, 16'h0E11);
    setCounters(3,  16'h2468, 20'hF1357, 16'h9753, 16'hA864);
    setCounters(4,  16'h1111, 20'hC2222, 16'h3333, 16'h4444);
    setCounters(5,  16'h567B, 20'h89012, 16'h345D, 16'h6789);
    setCounters(6,  16'h90E2, 20'h13579, 16'h0F24, 16'h6802);
    setCounters(7,  16'h3A56, 20'h70812, 16'h3C56, 16'h7890);
    setCounters(8,  16'hF876, 20'h54321, 16'h9876, 16'h5432);
    setCounters(9,  16'hABCD, 20'hEF012, 16'h3456, 16'h789A);
    setCounters(10, 16'h0000, 20'h00009, 16'h0000, 16'h0008);
    setCounters(11, 16'h1357, 20'h24B68, 16'h9753, 16'h86E4);
    setCounters(12, 16'h2021, 20'h22F32, 16'h4252, 16'h6202);
    setCounters(13, 16'h9999, 20'h9D999, 16'h9999, 16'hA999);
    setCounters(14, 16'h0101, 20'hB0101, 16'h0101, 16'h0101);
    setCounters(15, 16'h2345, 20'h67890, 16'h1234, 16'h5678);
    setCounters(16, 16'h8765, 20'h432C0, 16'h9876, 16'h5432);
    setCounters(17, 16'h1E23, 20'h45678, 16'h9F01, 16'h2345);
    setCounters(18, 16'hB123, 20'h45678, 16'h7012, 16'h3456);
    setCounters(19, 16'h0246, 20'h81357, 16'h9024, 16'h6813);
    setCounters(20, 16'h5555, 20'h6666A, 16'h7777, 16'h888B);
    setCounters(21, 16'h1029, 20'h384C7, 16'h5610, 16'h29D8);
    setCounters(22, 16'h4738, 20'h29E01, 16'h5647, 16'h38F9);
    setCounters(23, 16'h0011, 20'h22330, 16'h4455, 16'h6677);
endtask

// Rows from the LFSR, expected values built frame by frame
task automatic prepareTable();
    logic [31:0]             lfsr;
    logic [`IO_KEY_BITS-1:0] keyMap;
    lfsr   = 32'h38f927d2;
    keyMap = '0;
    loadCounters();
    for (int k = 0; k < frameCount; k++) begin
        for (int b = 0; b < 7; b++) begin
            lfsr = lfsrStep(lfsr);
            frameTable[k].kb[b] = lfsr[0];  // One step per bit
        end
        frameTable[k].cathode = modelCathode(frameTable[k], k % `IO_ANODES);
        frameTable[k].anode   = 8'(k % `IO_ANODES);
        frameTable[k].column  = 8'(1) << (k % `IO_KB_COLUMNS);
        keyMap[`IO_KB_ROWS_USED*(k % `IO_KB_COLUMNS) +: `IO_KB_ROWS_USED] =
            frameTable[k].kb[`IO_KB_ROWS_USED-1:0];
        frameTable[k].keys = keyMap;
    end
endtask

`endif

/* testbench/tbIoKeyDisplay.sv */
`timescale 1ns/10ps

`include "io_defs.svh"

module tbIoKeyDisplay;

    logic                    Clock_1us = 1'b0;
    logic                    reset;
    logic [6:0]              keyboardData;
    logic [15:0]             ipCounter;
    logic [19:0]             loopCounter;
    logic [15:0]             apCounter;
    logic [15:0]             dataCounter;
    logic [7:0]              emulData;
    logic                    in12Clear;
    logic                    in12WriteCathode;
    logic                    in12WriteAnode;
    logic                    keyboardWrite;
    logic [`IO_KEY_BITS-1:0] keysCurrentState;
    logic [`IO_KEY_BITS-1:0] heldKeys;  // Key map expected between frames
    int                      cycleCount = 0;
    int                      currentFrame = 0;

    `include "ioStimulus.svh"

    localparam int timeoutLimit = frameCount * (`IO_SCAN_DIVIDE + 8) + 100;

    ioKeyDisplay DUT (
        .Clock_1us        (Clock_1us),
        .reset            (reset),
        .keyboardData     (keyboardData),
        .ipCounter        (ipCounter),
        .loopCounter      (loopCounter),
        .apCounter        (apCounter),
        .dataCounter      (dataCounter),
        .emulData         (emulData),
        .in12Clear        (in12Clear),
        .in12WriteCathode (in12WriteCathode),
        .in12WriteAnode   (in12WriteAnode),
        .keyboardWrite    (keyboardWrite),
        .keysCurrentState (keysCurrentState)
    );

    always #4 Clock_1us = ~Clock_1us;  // 8 ns period

    always @(posedge Clock_1us) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout: scan frames stopped arriving, frame %0d never finished",
                     currentFrame);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped at the cycle limit");
        end
    end

    task automatic failRun();
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first mismatch");
    endtask

    task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h in frame %0d",
                     name, got, exp, currentFrame);
            failRun();
        end
    endtask

    // Order is in12Clear, in12WriteCathode, in12WriteAnode, keyboardWrite
    task automatic checkStrobes(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("Error: strobes are 0x%h, expected 0x%h in frame %0d",
                     got, exp, currentFrame);
            failRun();
        end
    endtask

    task automatic checkKeys(input logic [`IO_KEY_BITS-1:0] got,
                             input logic [`IO_KEY_BITS-1:0] exp);
        if (got !== exp) begin
            $display("Error: keysCurrentState is 0x%h, expected 0x%h in frame %0d",
                     got, exp, currentFrame);
            failRun();
        end
    endtask

    task automatic checkPhase(input ioPkg::busPhase got, input ioPkg::busPhase exp);
        if (got !== exp) begin
            $display("Error: phase is 0x%h (%s), expected 0x%h (%s) in frame %0d",
                     got, got.name(), exp, exp.name(), currentFrame);
            failRun();
        end
    endtask

    task automatic checkCycle(input logic [3:0] expStrobes, input ioPkg::busPhase expPhase,
                              input logic [7:0] expData);
        checkStrobes({in12Clear, in12WriteCathode, in12WriteAnode, keyboardWrite}, expStrobes);
        checkPhase(DUT.phase, expPhase);
        checkByte("emulData", emulData, expData);
    endtask

    task automatic applyEntry(input int k);
        ipCounter    = frameTable[k].ip;
        loopCounter  = frameTable[k].loop;
        apCounter    = frameTable[k].ap;
        dataCounter  = frameTable[k].data;
        keyboardData = frameTable[k].kb;
    endtask

    // Idle cycles until the blanking strobe shows up
    task automatic waitFrameStart();
        @(negedge Clock_1us);
        while (!in12Clear) begin
            checkCycle(4'b0000, ioPkg::PhaseIdle, 8'h00);
            checkKeys(keysCurrentState, heldKeys);
            @(negedge Clock_1us);
        end
    endtask

    initial begin
        reset        = 1'b1;
        keyboardData = '0;
        ipCounter    = '0;
        loopCounter  = '0;
        apCounter    = '0;
        dataCounter  = '0;
        heldKeys     = '0;
        prepareTable();
        repeat (5) @(posedge Clock_1us);
        @(negedge Clock_1us);
        reset = 1'b0;
        @(negedge Clock_1us);
        checkCycle(4'b0000, ioPkg::PhaseIdle, 8'h00);
        checkKeys(keysCurrentState, heldKeys);
        for (int k = 0; k < frameCount; k++) begin
            currentFrame = k;
            applyEntry(k);  // Held through the whole frame
            waitFrameStart();
            checkCycle(4'b1000, ioPkg::PhaseBlank, 8'h00);
            @(negedge Clock_1us);
            checkCycle(4'b0100, ioPkg::PhaseCathodes, frameTable[k].cathode);
            @(negedge Clock_1us);
            checkCycle(4'b0010, ioPkg::PhaseAnodes, frameTable[k].anode);
            @(negedge Clock_1us);
            checkCycle(4'b0001, ioPkg::PhaseKeyWrite, frameTable[k].column);
            @(negedge Clock_1us);
            checkCycle(4'b0000, ioPkg::PhaseKeyRead, 8'h00);
            @(negedge Clock_1us);
            checkCycle(4'b0000, ioPkg::PhaseStop, 8'h00);
            checkKeys(keysCurrentState, frameTable[k].keys);
            heldKeys = frameTable[k].keys;
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* flist.f */
+incdir+design
+incdir+testbench
design/ioPkg.sv
design/scanTimer.sv
design/cathodeSelect.sv
design/keyboardScanner.sv
design/busSequencer.sv
design/ioKeyDisplay.sv
testbench/tbIoKeyDisplay.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tbIoKeyDisplay -f flist.f \
    > build.log 2>&1 &&
./obj_dir/VtbIoKeyDisplay > sim.log 2>&1 ||
echo "Build or simulation exited with an error, see build.log and sim.log"

grep -q "NO ERRORS" sim.log 2>/dev/null && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
